/* Makefile */
# Verilator build and run for the stream data path testbench

VERILATOR ?= verilator
SIM_TOP   ?= tb_axis_path
RTL_TOP   ?= axis_path_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(SIM_TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(SIM_TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(SIM_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/axis_cfg_pkg.sv */
// stream configuration: beat widths, payload types, slice modes and pipeline depth
`default_nettype none

package axis_cfg_pkg;

   // -------------------------------------------------------------------------
   // beat widths
   // -------------------------------------------------------------------------
   localparam int TDATA_WIDTH = 64;
   localparam int TKEEP_WIDTH = TDATA_WIDTH / 8;  // one enable per byte
   localparam int TUSER_WIDTH = 8;                // side-band, passed untouched

   typedef logic [TDATA_WIDTH-1:0] tdata_t;
   typedef logic [TKEEP_WIDTH-1:0] tkeep_t;
   typedef logic [TUSER_WIDTH-1:0] tuser_t;

   // -------------------------------------------------------------------------
   // register slice behaviour
   // -------------------------------------------------------------------------
   typedef enum logic [1:0] {
      SLICE_SKID,    // fully registered tready
      SLICE_SIMPLE,  // tready from downstream
      SLICE_BYPASS   // wires only
   } slice_mode_e;

   // entries held by a skid slice
   typedef enum logic [1:0] {
      EMPTY,
      ONE,
      TWO
   } skid_state_e;

   // -------------------------------------------------------------------------
   // pipeline used by the top level
   // -------------------------------------------------------------------------
   localparam int unsigned PL_DEPTH = 2;
   localparam slice_mode_e PL_MODE  = SLICE_SKID;

endpackage : axis_cfg_pkg

`default_nettype wire

/* design/axis_if.sv */
// AXI-stream bundle with source and sink views for links inside the data path
`default_nettype none

interface axis_if;

   logic                 tvalid;
   logic                 tready;
   axis_cfg_pkg::tdata_t tdata;
   axis_cfg_pkg::tkeep_t tkeep;
   logic                 tlast;
   axis_cfg_pkg::tuser_t tuser;

   // beat producer
   modport source (
      output tvalid,
      output tdata,
      output tkeep,
      output tlast,
      output tuser,
      input  tready
   );

   // beat consumer
   modport sink (
      input  tvalid,
      input  tdata,
      input  tkeep,
      input  tlast,
      input  tuser,
      output tready
   );

endinterface : axis_if

`default_nettype wire

/* design/axis_path_top.sv */
// streaming data path top, register slice pipeline followed by a statistics tap
`default_nettype none

module axis_path_top (
   input  wire logic                  clk,
   input  wire logic                  arst_n,
   input  wire logic                  stats_clr,
   // upstream stream
   input  wire logic                  s_tvalid,
   output logic                       s_tready,
   input  wire axis_cfg_pkg::tdata_t  s_tdata,
   input  wire axis_cfg_pkg::tkeep_t  s_tkeep,
   input  wire axis_cfg_pkg::tuser_t  s_tuser,
   input  wire logic                  s_tlast,
   // downstream stream
   output logic                       m_tvalid,
   input  wire logic                  m_tready,
   output axis_cfg_pkg::tdata_t       m_tdata,
   output axis_cfg_pkg::tkeep_t       m_tkeep,
   output axis_cfg_pkg::tuser_t       m_tuser,
   output logic                       m_tlast,
   // statistics
   output axis_stats_pkg::pkt_cnt_t   pkt_count,
   output axis_stats_pkg::byte_cnt_t  byte_count
);

   axis_if pipe_in ();
   axis_if pipe_out ();
   axis_if tap_out ();

   assign pipe_in.tvalid = s_tvalid;
   assign pipe_in.tdata  = s_tdata;
   assign pipe_in.tkeep  = s_tkeep;
   assign pipe_in.tuser  = s_tuser;
   assign pipe_in.tlast  = s_tlast;
   assign s_tready       = pipe_in.tready;

   axis_pipeline #(
      .DEPTH (axis_cfg_pkg::PL_DEPTH),
      .MODE  (axis_cfg_pkg::PL_MODE)
   ) u_pipeline (
      .clk    (clk),
      .arst_n (arst_n),
      .axis_s (pipe_in),
      .axis_m (pipe_out)
   );

   axis_stats_tap u_stats_tap (
      .clk        (clk),
      .arst_n     (arst_n),
      .stats_clr  (stats_clr),
      .axis_s     (pipe_out),
      .axis_m     (tap_out),
      .pkt_count  (pkt_count),
      .byte_count (byte_count)
   );

   assign m_tvalid       = tap_out.tvalid;
   assign m_tdata        = tap_out.tdata;
   assign m_tkeep        = tap_out.tkeep;
   assign m_tuser        = tap_out.tuser;
   assign m_tlast        = tap_out.tlast;
   assign tap_out.tready = m_tready;  // tap hands ready straight back

endmodule : axis_path_top

`default_nettype wire

/* design/axis_pipeline.sv */
// AXI-stream pipeline generator chaining a configurable number of register slices
`default_nettype none

module axis_pipeline #(
   parameter int unsigned               DEPTH = axis_cfg_pkg::PL_DEPTH,
   parameter axis_cfg_pkg::slice_mode_e MODE  = axis_cfg_pkg::PL_MODE
) (
   input  wire logic clk,
   input  wire logic arst_n,
   axis_if.sink      axis_s,
   axis_if.source    axis_m
);

   generate
      if (DEPTH == 0) begin : g_thru
         // no stages, plain connection
         assign axis_m.tvalid = axis_s.tvalid;
         assign axis_m.tdata  = axis_s.tdata;
         assign axis_m.tkeep  = axis_s.tkeep;
         assign axis_m.tuser  = axis_s.tuser;
         assign axis_m.tlast  = axis_s.tlast;
         assign axis_s.tready = axis_m.tready;
      end else begin : g_chain
         axis_if axis_pl [DEPTH:0] ();  // link n feeds stage n

         // ----------------------------------------------------------------------
         // chain ends
         // ----------------------------------------------------------------------
         assign axis_pl[0].tvalid = axis_s.tvalid;
         assign axis_pl[0].tdata  = axis_s.tdata;
         assign axis_pl[0].tkeep  = axis_s.tkeep;
         assign axis_pl[0].tuser  = axis_s.tuser;
         assign axis_pl[0].tlast  = axis_s.tlast;
         assign axis_s.tready     = axis_pl[0].tready;

         assign axis_m.tvalid         = axis_pl[DEPTH].tvalid;
         assign axis_m.tdata          = axis_pl[DEPTH].tdata;
         assign axis_m.tkeep          = axis_pl[DEPTH].tkeep;
         assign axis_m.tuser          = axis_pl[DEPTH].tuser;
         assign axis_m.tlast          = axis_pl[DEPTH].tlast;
         assign axis_pl[DEPTH].tready = axis_m.tready;

         // ----------------------------------------------------------------------
         // slices
         // ----------------------------------------------------------------------
         for (genvar n = 0; n < DEPTH; n++) begin : g_stage
            axis_register #(
               .MODE (MODE)
            ) u_reg (
               .clk    (clk),
               .arst_n (arst_n),
               .s      (axis_pl[n]),
               .m      (axis_pl[n+1])
            );
         end
      end
   endgenerate

endmodule : axis_pipeline

`default_nettype wire

/* design/axis_register.sv */
// AXI-stream register slice, selectable as skid buffer, simple buffer or bypass
`default_nettype none

module axis_register #(
   parameter axis_cfg_pkg::slice_mode_e MODE = axis_cfg_pkg::SLICE_SKID
) (
   input  wire logic clk,
   input  wire logic arst_n,
   axis_if.sink      s,
   axis_if.source    m
);

   generate
      if (MODE == axis_cfg_pkg::SLICE_SKID) begin : g_skid
         // ----------------------------------------------------------------------
         // skid buffer: main register drives m, skid catches the overflow beat
         // ----------------------------------------------------------------------
         axis_cfg_pkg::skid_state_e state_q, state_nxt;
         logic                      ready_q;
         logic                      in_xfer, out_xfer;
         logic                      load_main, load_skid;

         axis_cfg_pkg::tdata_t main_tdata, skid_tdata;
         axis_cfg_pkg::tkeep_t main_tkeep, skid_tkeep;
         axis_cfg_pkg::tuser_t main_tuser, skid_tuser;
         logic                 main_tlast, skid_tlast;

         assign in_xfer  = s.tvalid && ready_q;
         assign out_xfer = (state_q != axis_cfg_pkg::EMPTY) && m.tready;

         always_comb begin
            state_nxt = state_q;
            case (state_q)
               axis_cfg_pkg::EMPTY: begin
                  if (in_xfer) state_nxt = axis_cfg_pkg::ONE;
               end
               axis_cfg_pkg::ONE: begin
                  if (in_xfer && !out_xfer) begin
                     state_nxt = axis_cfg_pkg::TWO;
                  end else if (!in_xfer && out_xfer) begin
                     state_nxt = axis_cfg_pkg::EMPTY;
                  end
               end
               axis_cfg_pkg::TWO: begin
                  if (out_xfer) state_nxt = axis_cfg_pkg::ONE;  // skid moves up
               end
               default: state_nxt = axis_cfg_pkg::EMPTY;
            endcase
         end

         always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
               state_q <= axis_cfg_pkg::EMPTY;
               ready_q <= 1'b0;  // held low until reset is gone
            end else begin
               state_q <= state_nxt;
               ready_q <= (state_nxt != axis_cfg_pkg::TWO);
            end
         end

         // main loads from the input unless the skid entry is waiting
         assign load_main = (state_q == axis_cfg_pkg::EMPTY && in_xfer) ||
                            (state_q == axis_cfg_pkg::ONE && in_xfer && out_xfer) ||
                            (state_q == axis_cfg_pkg::TWO && out_xfer);
         assign load_skid = (state_q == axis_cfg_pkg::ONE) && in_xfer && !out_xfer;

         always_ff @(posedge clk) begin
            if (load_main) begin
               if (state_q == axis_cfg_pkg::TWO) begin
                  main_tdata <= skid_tdata;
                  main_tkeep <= skid_tkeep;
                  main_tuser <= skid_tuser;
                  main_tlast <= skid_tlast;
               end else begin
                  main_tdata <= s.tdata;
                  main_tkeep <= s.tkeep;
                  main_tuser <= s.tuser;
                  main_tlast <= s.tlast;
               end
            end
            if (load_skid) begin
               skid_tdata <= s.tdata;
               skid_tkeep <= s.tkeep;
               skid_tuser <= s.tuser;
               skid_tlast <= s.tlast;
            end
         end

         assign s.tready = ready_q;
         assign m.tvalid = (state_q != axis_cfg_pkg::EMPTY);
         assign m.tdata  = main_tdata;
         assign m.tkeep  = main_tkeep;
         assign m.tuser  = main_tuser;
         assign m.tlast  = main_tlast;

         // upstream must see ready low once both entries are taken
         a_no_accept_when_full : assert property (@(posedge clk) disable iff (!arst_n)
            (state_q == axis_cfg_pkg::TWO) |-> !(s.tvalid && s.tready))
            else $error("skid slice accepted a beat while full");

      end else if (MODE == axis_cfg_pkg::SLICE_SIMPLE) begin : g_simple
         // ----------------------------------------------------------------------
         // simple buffer: single register, ready follows downstream
         // ----------------------------------------------------------------------
         logic                 valid_q;
         logic                 run_q;  // low through reset, keeps tready down
         logic                 ready;
         axis_cfg_pkg::tdata_t tdata_q;
         axis_cfg_pkg::tkeep_t tkeep_q;
         axis_cfg_pkg::tuser_t tuser_q;
         logic                 tlast_q;

         assign ready = run_q && (!valid_q || m.tready);

         always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
               valid_q <= 1'b0;
               run_q   <= 1'b0;
            end else begin
               run_q <= 1'b1;
               if (ready) valid_q <= s.tvalid;  // refill or drain
            end
         end

         always_ff @(posedge clk) begin
            if (ready && s.tvalid) begin
               tdata_q <= s.tdata;
               tkeep_q <= s.tkeep;
               tuser_q <= s.tuser;
               tlast_q <= s.tlast;
            end
         end

         assign s.tready = ready;
         assign m.tvalid = valid_q;
         assign m.tdata  = tdata_q;
         assign m.tkeep  = tkeep_q;
         assign m.tuser  = tuser_q;
         assign m.tlast  = tlast_q;

      end else begin : g_bypass
         assign s.tready = m.tready;  // straight wires
         assign m.tvalid = s.tvalid;
         assign m.tdata  = s.tdata;
         assign m.tkeep  = s.tkeep;
         assign m.tuser  = s.tuser;
         assign m.tlast  = s.tlast;
      end
   endgenerate

   // stalled output beat must not change until it is taken
   a_m_stable : assert property (@(posedge clk) disable iff (!arst_n)
      (m.tvalid && !m.tready) |=>
         (m.tvalid && $stable({m.tdata, m.tkeep, m.tuser, m.tlast})))
      else $error("output payload changed while stalled");

endmodule : axis_register

`default_nettype wire

/* design/axis_stats_pkg.sv */
// statistics tap types: packet and byte counter widths
`default_nettype none

package axis_stats_pkg;

   // -------------------------------------------------------------------------
   // counter widths
   // -------------------------------------------------------------------------
   localparam int PKT_CNT_WIDTH  = 32;
   localparam int BYTE_CNT_WIDTH = 40;  // wide enough for long byte runs

   typedef logic [PKT_CNT_WIDTH-1:0]  pkt_cnt_t;
   typedef logic [BYTE_CNT_WIDTH-1:0] byte_cnt_t;

endpackage : axis_stats_pkg

`default_nettype wire

/* design/axis_stats_tap.sv */
// AXI-stream statistics tap, passes beats through and counts packets and bytes
`default_nettype none

module axis_stats_tap (
   input  wire logic                  clk,
   input  wire logic                  arst_n,
   input  wire logic                  stats_clr,
   axis_if.sink                       axis_s,
   axis_if.source                     axis_m,
   output axis_stats_pkg::pkt_cnt_t   pkt_count,
   output axis_stats_pkg::byte_cnt_t  byte_count
);

   logic                      xfer;
   axis_stats_pkg::pkt_cnt_t  pkt_q;
   axis_stats_pkg::byte_cnt_t byte_q;

   // number of enabled bytes in a beat
   function automatic axis_stats_pkg::byte_cnt_t keep_bytes(input axis_cfg_pkg::tkeep_t keep);
      axis_stats_pkg::byte_cnt_t n;
      n = '0;
      for (int i = 0; i < axis_cfg_pkg::TKEEP_WIDTH; i++) begin
         n = n + axis_stats_pkg::byte_cnt_t'(keep[i]);
      end
      return n;
   endfunction

   // ------------------------------------------------------------------------
   // pass-through, no added latency
   // ------------------------------------------------------------------------
   assign axis_m.tvalid = axis_s.tvalid;
   assign axis_m.tdata  = axis_s.tdata;
   assign axis_m.tkeep  = axis_s.tkeep;
   assign axis_m.tuser  = axis_s.tuser;
   assign axis_m.tlast  = axis_s.tlast;
   assign axis_s.tready = axis_m.tready;

   assign xfer = axis_s.tvalid && axis_m.tready;  // beat leaves this edge

   // ------------------------------------------------------------------------
   // counters
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pkt_q  <= '0;
         byte_q <= '0;
      end else if (stats_clr) begin
         pkt_q  <= '0;  // clear wins over a same-edge beat
         byte_q <= '0;
      end else if (xfer) begin
         byte_q <= byte_q + keep_bytes(axis_s.tkeep);
         if (axis_s.tlast) pkt_q <= pkt_q + 1'b1;
      end
   end

   assign pkt_count  = pkt_q;
   assign byte_count = byte_q;

   // an empty beat would leave the byte count behind the packet count
   a_keep_nonzero : assert property (@(posedge clk) disable iff (!arst_n)
      xfer |-> (axis_s.tkeep != '0))
      else $error("accepted beat with tkeep all zero");

endmodule : axis_stats_tap

`default_nettype wire

/* dv/tb_axis_path.sv */
// testbench for the stream data path with random packets checked against a queue model
`default_nettype none

module tb_axis_path;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int SEED     = 6;
   localparam int NUM_PKTS = 120;
   localparam int TIMEOUT  = 400;  // cycles per wait loop

   typedef struct {
      axis_cfg_pkg::tdata_t tdata;
      axis_cfg_pkg::tkeep_t tkeep;
      axis_cfg_pkg::tuser_t tuser;
      logic                 tlast;
      int unsigned          cyc;
   } beat_t;

   logic clk, arst_n, stats_clr;
   logic s_tvalid, s_tready, s_tlast;
   logic m_tvalid, m_tready, m_tlast;
   axis_cfg_pkg::tdata_t s_tdata, m_tdata;
   axis_cfg_pkg::tkeep_t s_tkeep, m_tkeep;
   axis_cfg_pkg::tuser_t s_tuser, m_tuser;
   axis_stats_pkg::pkt_cnt_t  pkt_count;
   axis_stats_pkg::byte_cnt_t byte_count;

   beat_t       exp_q[$];
   beat_t       held;
   logic        stalled   = 1'b0;
   logic        lat_check = 1'b0;
   logic        ready_mode = 1'b0;  // 0 keeps m_tready high
   int          ready_pct = 100;
   int          stretch   = 0;
   int unsigned cycle     = 0;
   int          errors    = 0;
   axis_stats_pkg::pkt_cnt_t  exp_pkts  = '0;
   axis_stats_pkg::byte_cnt_t exp_bytes = '0;

   tb_clkgen #(.PERIOD_NS(8)) u_clkgen (.clk(clk));

   axis_path_top u_dut (
      .clk        (clk),
      .arst_n     (arst_n),
      .stats_clr  (stats_clr),
      .s_tvalid   (s_tvalid),
      .s_tready   (s_tready),
      .s_tdata    (s_tdata),
      .s_tkeep    (s_tkeep),
      .s_tuser    (s_tuser),
      .s_tlast    (s_tlast),
      .m_tvalid   (m_tvalid),
      .m_tready   (m_tready),
      .m_tdata    (m_tdata),
      .m_tkeep    (m_tkeep),
      .m_tuser    (m_tuser),
      .m_tlast    (m_tlast),
      .pkt_count  (pkt_count),
      .byte_count (byte_count)
   );

   task automatic compare_value(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
      assert (exp === act) else begin
         errors++;
         $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act);
      end
   endtask

   task automatic note_timeout(input string what);
      errors++;
      $display("timeout while waiting for %s", what);
   endtask

   // holds the beat until s_tready is seen so the transfer lands on the next rising edge
   task automatic send_beat(input logic last, input axis_cfg_pkg::tkeep_t keep);
      int n;
      n = 0;
      s_tvalid = 1'b1;
      s_tdata  = {$urandom, $urandom};
      s_tuser  = axis_cfg_pkg::tuser_t'($urandom);
      s_tkeep  = keep;
      s_tlast  = last;
      while (!s_tready && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (!s_tready) note_timeout("s_tready during a beat");
      @(negedge clk);
      s_tvalid = 1'b0;
   endtask

   task automatic send_packet(input int unsigned len, input int unsigned max_gap);
      axis_cfg_pkg::tkeep_t keep;
      int unsigned          nbytes;
      for (int unsigned i = 0; i < len; i++) begin
         keep = '1;
         if (i == len - 1) begin
            nbytes = $urandom_range(1, axis_cfg_pkg::TKEEP_WIDTH);
            keep   = keep >> (axis_cfg_pkg::TKEEP_WIDTH - nbytes);  // low bytes only
         end
         if (max_gap != 0 && $urandom_range(0, 2) == 0) begin
            repeat ($urandom_range(1, max_gap)) @(negedge clk);
         end
         send_beat(i == len - 1, keep);
      end
   endtask

   task automatic drain_output();
      int n;
      n = 0;
      ready_mode = 1'b0;
      while (exp_q.size() != 0 && n < TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() != 0) note_timeout("the output to drain");
      repeat (8) @(negedge clk);  // any extra beat shows up in the monitor
      compare_value("m_tvalid", 64'd0, 64'(m_tvalid));
   endtask

   // ------------------------------------------------------------------------
   // downstream ready with random stretches of stall and flow
   // ------------------------------------------------------------------------
   always @(negedge clk) begin
      if (!ready_mode) begin
         m_tready = 1'b1;
      end else if (stretch == 0) begin
         m_tready = ($urandom_range(0, 99) < ready_pct);
         stretch  = $urandom_range(1, 16);
      end else begin
         stretch--;
      end
   end

   // ------------------------------------------------------------------------
   // monitor and model sampled on the rising edge
   // ------------------------------------------------------------------------
   always @(posedge clk) begin
      beat_t b;
      if (arst_n) begin
         cycle++;
         compare_value("pkt_count", 64'(exp_pkts), 64'(pkt_count));  // state of last edge
         compare_value("byte_count", 64'(exp_bytes), 64'(byte_count));
         if (stalled) begin
            assert (m_tvalid) else begin
               errors++;
               $display("m_tvalid dropped before the stalled beat was taken");
            end
            compare_value("m_tdata (stalled)", held.tdata, m_tdata);
         end
         stalled = m_tvalid && !m_tready;
         held    = '{m_tdata, m_tkeep, m_tuser, m_tlast, cycle};
         if (s_tvalid && s_tready) exp_q.push_back('{s_tdata, s_tkeep, s_tuser, s_tlast, cycle});
         if (m_tvalid && m_tready) begin
            assert (exp_q.size() != 0) else begin
               errors++;
               $display("output beat appeared with no matching input beat");
            end
            if (exp_q.size() != 0) begin
               b = exp_q.pop_front();
               compare_value("m_tdata", b.tdata, m_tdata);
               compare_value("m_tkeep", 64'(b.tkeep), 64'(m_tkeep));
               compare_value("m_tuser", 64'(b.tuser), 64'(m_tuser));
               compare_value("m_tlast", 64'(b.tlast), 64'(m_tlast));
               if (lat_check) begin
                  compare_value("latency", 64'(axis_cfg_pkg::PL_DEPTH), 64'(cycle - b.cyc));
               end
               exp_bytes += axis_stats_pkg::byte_cnt_t'($countones(b.tkeep));
               if (b.tlast) exp_pkts++;
            end
         end
         if (stats_clr) begin
            exp_pkts  = '0;  // clear beats a same-edge transfer
            exp_bytes = '0;
         end
      end
   end

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------
   initial begin
      int n;
      n = $urandom(SEED);
      arst_n    = 1'b0;
      stats_clr = 1'b0;
      s_tvalid  = 1'b0;
      s_tdata   = '0;
      s_tkeep   = '0;
      s_tuser   = '0;
      s_tlast   = 1'b0;
      m_tready  = 1'b1;

      repeat (5) begin
         @(posedge clk);
         @(negedge clk);
         compare_value("m_tvalid (reset)", 64'd0, 64'(m_tvalid));
         compare_value("s_tready (reset)", 64'd0, 64'(s_tready));
         compare_value("pkt_count (reset)", 64'd0, 64'(pkt_count));
         compare_value("byte_count (reset)", 64'd0, 64'(byte_count));
      end
      arst_n = 1'b1;
      compare_value("m_tvalid (release)", 64'd0, 64'(m_tvalid));
      compare_value("pkt_count (release)", 64'd0, 64'(pkt_count));
      compare_value("byte_count (release)", 64'd0, 64'(byte_count));
      n = 0;
      while (!s_tready && n < 8) begin
         @(negedge clk);
         n++;
      end
      if (!s_tready) note_timeout("s_tready after reset");

      // light then heavy back-pressure
      ready_mode = 1'b1;
      ready_pct  = 70;
      repeat (NUM_PKTS / 2) send_packet($urandom_range(1, 8), 3);
      ready_pct = 25;
      repeat (NUM_PKTS / 2) send_packet($urandom_range(1, 8), 2);
      drain_output();

      // single beats into an empty pipeline
      lat_check = 1'b1;
      repeat (6) begin
         send_packet(1, 0);
         repeat (5) @(negedge clk);
      end
      drain_output();
      lat_check = 1'b0;

      // counter clear while idle and counting again after it
      stats_clr = 1'b1;
      @(negedge clk);
      stats_clr = 1'b0;
      compare_value("pkt_count (clear)", 64'd0, 64'(pkt_count));
      compare_value("byte_count (clear)", 64'd0, 64'(byte_count));
      ready_mode = 1'b1;
      ready_pct  = 50;
      repeat (20) send_packet($urandom_range(1, 8), 3);
      drain_output();

      assert (exp_q.size() == 0) else begin
         errors++;
         $display("%0d beats never reached the output", exp_q.size());
      end
      $display("error count %0d", errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule : tb_axis_path

`default_nettype wire

/* dv/tb_clkgen.sv */
// testbench clock source, free running square wave
`default_nettype none

module tb_clkgen #(
   parameter int PERIOD_NS = 8
) (
   output logic clk
);

   timeunit 1ns;
   timeprecision 100ps;

   initial clk = 1'b0;

   always #(PERIOD_NS / 2) clk = ~clk;  // 50 % duty

endmodule : tb_clkgen

`default_nettype wire

/* tb.f */
design/axis_cfg_pkg.sv
design/axis_stats_pkg.sv
design/axis_if.sv
design/axis_register.sv
design/axis_pipeline.sv
design/axis_stats_tap.sv
design/axis_path_top.sv
dv/tb_clkgen.sv
dv/tb_axis_path.sv
